// ==== src/ex_pkg.sv ====
// Shared definitions for the execute stage
//   Operator encodings for the ALU, multiplier and divider
//   Register index type
//   ID/EX and EX/WB pipeline structs, controller struct
//   Multiplier and divider latency constants

`default_nettype none

package ex_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Operator encodings
  ////////////////////////////////////////////////////////////////////////////

  // ALU operators
  // Values from EQ upward also drive the compare result bit
  typedef enum logic [3:0] {
    ADD  = 4'd0,
    SUB  = 4'd1,
    XOR  = 4'd2,
    OR   = 4'd3,
    AND  = 4'd4,
    SLL  = 4'd5,
    SRL  = 4'd6,
    SRA  = 4'd7,
    SLT  = 4'd8,
    SLTU = 4'd9,
    EQ   = 4'd10,
    NE   = 4'd11,
    LT   = 4'd12,
    GE   = 4'd13,
    LTU  = 4'd14,
    GEU  = 4'd15
  } alu_op_e;

  // Multiplier operators, MUL returns the low word and the rest the high word
  typedef enum logic [1:0] {
    MUL    = 2'd0,
    MULH   = 2'd1,
    MULHSU = 2'd2,
    MULHU  = 2'd3
  } mul_op_e;

  // Divider operators
  typedef enum logic [1:0] {
    DIV  = 2'd0,
    DIVU = 2'd1,
    REM  = 2'd2,
    REMU = 2'd3
  } div_op_e;

  typedef logic [4:0] rf_addr_t;

  ////////////////////////////////////////////////////////////////////////////
  // Pipeline structs
  ////////////////////////////////////////////////////////////////////////////

  // Instruction as presented by decode
  typedef struct packed {
    logic        instr_valid;
    logic [31:0] pc;
    logic        alu_en;
    logic        mul_en;
    logic        div_en;
    alu_op_e     alu_operator;
    mul_op_e     mul_operator;
    div_op_e     div_operator;
    logic [31:0] operand_a;
    logic [31:0] operand_b;
    // Branch target
    logic [31:0] operand_c;
    logic        rf_we;
    rf_addr_t    rf_waddr;
  } id_ex_pipe_t;

  // EX/WB pipeline register
  typedef struct packed {
    logic        instr_valid;
    logic        rf_we;
    rf_addr_t    rf_waddr;
    logic [31:0] rf_wdata;
    logic [31:0] pc;
  } ex_wb_pipe_t;

  // Level controls from the controller FSM
  typedef struct packed {
    logic kill_ex;
    logic halt_ex;
  } ctrl_fsm_t;

  // Worst case divider latency, first valid_i cycle to valid_o
  localparam int unsigned DIV_MAX_CYCLES = 35;
  // Fixed multiplier latency
  localparam int unsigned MUL_CYCLES = 2;

endpackage

`default_nettype wire

// ==== src/ex_alu.sv ====
// Single-cycle ALU of the execute stage
//   Shared adder for add/sub, set-less-than and branch compares
//   One barrel shifter for SLL/SRL/SRA, lent to the divider for its divisor
//   Leading-zero counter used by the divider

`timescale 1ns/1ps
`default_nettype none

module ex_alu import ex_pkg::*; (
  input  alu_op_e     operator_i,
  input  logic [31:0] operand_a_i,
  input  logic [31:0] operand_b_i,
  // Divider access to the leading-zero counter
  input  logic        div_clz_en_i,
  input  logic [31:0] div_clz_data_i,
  output logic [5:0]  div_clz_result_o,
  // Divider access to the shifter
  input  logic        div_shift_en_i,
  input  logic [5:0]  div_shift_amt_i,
  output logic [31:0] div_op_b_shifted_o,
  output logic [31:0] result_o,
  output logic        cmp_result_o
);

  logic        sub;
  logic [32:0] adder_result;
  logic        is_equal;
  logic        is_less_s;
  logic        is_less_u;
  logic        shift_left;
  logic        shift_arith;
  logic [5:0]  shift_amt;
  logic [31:0] shift_src;
  logic [31:0] shift_in;
  logic [32:0] shift_wide;
  logic [31:0] shift_result;
  logic [5:0]  clz_count;

  function automatic logic [31:0] bit_rev(input logic [31:0] d);
    for (int i = 0; i < 32; i++) begin
      bit_rev[i] = d[31-i];
    end
  endfunction

  // Everything but ADD subtracts, carry out then means a >= b unsigned
  assign sub          = (operator_i != ADD);
  assign adder_result = {1'b0, operand_a_i} + {1'b0, operand_b_i ^ {32{sub}}} + 33'(sub);

  assign is_equal  = (adder_result[31:0] == 32'd0);
  assign is_less_u = !adder_result[32];
  // Differing signs decide on their own
  assign is_less_s = (operand_a_i[31] != operand_b_i[31]) ? operand_a_i[31] : adder_result[31];

  ////////////////////////////////////////////////////////////////////////////
  // Shifter
  ////////////////////////////////////////////////////////////////////////////

  // Right shifter only, left shifts go through bit reversal
  // Divider requests take priority and shift operand_b left
  assign shift_left   = div_shift_en_i || (operator_i == SLL);
  assign shift_arith  = !div_shift_en_i && (operator_i == SRA);
  assign shift_amt    = div_shift_en_i ? div_shift_amt_i : {1'b0, operand_b_i[4:0]};
  assign shift_src    = div_shift_en_i ? operand_b_i : operand_a_i;
  assign shift_in     = shift_left ? bit_rev(shift_src) : shift_src;
  assign shift_wide   = $signed({shift_arith & shift_in[31], shift_in}) >>> shift_amt;
  assign shift_result = shift_left ? bit_rev(shift_wide[31:0]) : shift_wide[31:0];

  assign div_op_b_shifted_o = shift_result;

  // Leading zeros, highest set bit wins, 32 for a zero word
  always_comb begin
    clz_count = 6'd32;
    for (int i = 0; i < 32; i++) begin
      if (div_clz_data_i[i]) clz_count = 6'(31 - i);
    end
  end

  assign div_clz_result_o = div_clz_en_i ? clz_count : 6'd0;

  always_comb begin
    unique case (operator_i)
      EQ:        cmp_result_o = is_equal;
      NE:        cmp_result_o = !is_equal;
      LT, SLT:   cmp_result_o = is_less_s;
      GE:        cmp_result_o = !is_less_s;
      LTU, SLTU: cmp_result_o = is_less_u;
      GEU:       cmp_result_o = !is_less_u;
      default:   cmp_result_o = 1'b0;
    endcase
  end

  always_comb begin
    unique case (operator_i)
      ADD, SUB:      result_o = adder_result[31:0];
      XOR:           result_o = operand_a_i ^ operand_b_i;
      OR:            result_o = operand_a_i | operand_b_i;
      AND:           result_o = operand_a_i & operand_b_i;
      SLL, SRL, SRA: result_o = shift_result;
      // Compares return the flag as a word
      default:       result_o = {31'd0, cmp_result_o};
    endcase
  end

endmodule

`default_nettype wire

// ==== src/ex_mult.sv ====
// Two-cycle multiplier
//   33x33 signed product captured in the first cycle
//   Low or high word presented with valid_o until ready_i

`timescale 1ns/1ps
`default_nettype none

module ex_mult import ex_pkg::*; (
  input  logic        clk,
  input  logic        rst_n,
  input  mul_op_e     operator_i,
  input  logic [31:0] op_a_i,
  input  logic [31:0] op_b_i,
  output logic [31:0] result_o,
  input  logic        valid_i,
  output logic        ready_o,
  output logic        valid_o,
  input  logic        ready_i
);

  typedef enum logic {MUL_IDLE, MUL_DONE} mul_state_e;

  mul_state_e         state_q;
  logic               sign_a;
  logic               sign_b;
  logic signed [65:0] product;
  logic [63:0]        product_q;
  logic               high_q;

  // Operand signedness per operator
  assign sign_a  = (operator_i == MULH) || (operator_i == MULHSU);
  assign sign_b  = (operator_i == MULH);
  assign product = $signed({sign_a & op_a_i[31], op_a_i}) *
                   $signed({sign_b & op_b_i[31], op_b_i});

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= MUL_IDLE;
    end else begin
      unique case (state_q)
        MUL_IDLE: if (valid_i) state_q <= MUL_DONE;
        // Dropped valid_i means kill or halt and discards the result
        MUL_DONE: if (ready_i || !valid_i) state_q <= MUL_IDLE;
        default:  state_q <= MUL_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state_q == MUL_IDLE && valid_i) begin
      product_q <= product[63:0];
      high_q    <= (operator_i != MUL);
    end
  end

  assign result_o = high_q ? product_q[63:32] : product_q[31:0];
  assign valid_o  = (state_q == MUL_DONE);
  // Accept the next instruction only as the result leaves
  assign ready_o  = (state_q == MUL_IDLE) ? !valid_i : ready_i;

  a_mul_hold: assert property (@(posedge clk) disable iff (!rst_n)
    valid_o && valid_i && !ready_i |=> valid_o && $stable(result_o));

endmodule

`default_nettype wire

// ==== src/ex_div.sv ====
// Iterative divider for DIV, DIVU, REM and REMU
//   Divisor normalized by the ALU leading-zero counter and shifter
//   One restoring step per cycle, clz+1 steps
//   Zero divisor and signed overflow corner results

`timescale 1ns/1ps
`default_nettype none

module ex_div import ex_pkg::*; (
  input  logic        clk,
  input  logic        rst_n,
  input  div_op_e     operator_i,
  input  logic [31:0] op_a_i,
  input  logic [31:0] op_b_i,
  // Borrowed ALU resources
  input  logic [5:0]  alu_clz_result_i,
  output logic        alu_clz_en_o,
  output logic [31:0] alu_clz_data_o,
  input  logic [31:0] alu_op_b_shifted_i,
  output logic        alu_shift_en_o,
  output logic [5:0]  alu_shift_amt_o,
  output logic [31:0] result_o,
  input  logic        valid_i,
  output logic        ready_o,
  output logic        valid_o,
  input  logic        ready_i
);

  typedef enum logic [1:0] {DIV_IDLE, DIV_CALC, DIV_DONE} div_state_e;

  div_state_e  state_q;
  logic [5:0]  cnt_q;
  logic        op_signed;
  logic        a_neg;
  logic        b_neg;
  logic [31:0] a_abs;
  logic [31:0] b_abs;
  logic        start;
  logic [31:0] divisor_init;
  logic [32:0] rem_diff;
  logic [31:0] quot_q;
  logic [31:0] rem_q;
  logic [31:0] divisor_q;
  logic        rem_sel_q;
  logic        quot_neg_q;
  logic        rem_neg_q;

  assign op_signed = (operator_i == DIV) || (operator_i == REM);
  assign a_neg     = op_signed && op_a_i[31];
  assign b_neg     = op_signed && op_b_i[31];
  assign a_abs     = a_neg ? -op_a_i : op_a_i;
  assign b_abs     = b_neg ? -op_b_i : op_b_i;
  assign start     = (state_q == DIV_IDLE) && valid_i;

  // Normalize in the start cycle through the ALU
  assign alu_clz_en_o    = start;
  assign alu_clz_data_o  = b_abs;
  assign alu_shift_en_o  = start;
  assign alu_shift_amt_o = alu_clz_result_i;
  // The ALU shifts the raw divisor, negating after the shift gives |b| << clz
  assign divisor_init    = b_neg ? -alu_op_b_shifted_i : alu_op_b_shifted_i;

  // Trial subtraction, no borrow means the step quotient bit is one
  assign rem_diff = {1'b0, rem_q} - {1'b0, divisor_q};

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= DIV_IDLE;
      cnt_q   <= 6'd0;
    end else begin
      unique case (state_q)
        DIV_IDLE: if (valid_i) begin
          state_q <= (op_b_i == 32'd0) ? DIV_DONE : DIV_CALC;
          cnt_q   <= alu_clz_result_i;
        end
        // Kill or halt drops valid_i and abandons the division
        DIV_CALC: begin
          cnt_q <= cnt_q - 6'd1;
          if (!valid_i) state_q <= DIV_IDLE;
          else if (cnt_q == 6'd0) state_q <= DIV_DONE;
        end
        DIV_DONE: if (ready_i || !valid_i) state_q <= DIV_IDLE;
        default:  state_q <= DIV_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (start) begin
      rem_sel_q <= (operator_i == REM) || (operator_i == REMU);
      if (op_b_i == 32'd0) begin
        // Divide by zero: all-ones quotient, dividend as remainder
        quot_q     <= '1;
        rem_q      <= op_a_i;
        quot_neg_q <= 1'b0;
        rem_neg_q  <= 1'b0;
      end else begin
        // Most negative / -1 falls out as that dividend with zero remainder
        quot_q     <= 32'd0;
        rem_q      <= a_abs;
        divisor_q  <= divisor_init;
        quot_neg_q <= a_neg ^ b_neg;
        rem_neg_q  <= a_neg;
      end
    end else if (state_q == DIV_CALC) begin
      quot_q    <= {quot_q[30:0], !rem_diff[32]};
      if (!rem_diff[32]) rem_q <= rem_diff[31:0];
      divisor_q <= divisor_q >> 1;
    end
  end

  // Sign fix on the way out
  assign result_o = rem_sel_q ? (rem_neg_q ? -rem_q : rem_q) :
                                (quot_neg_q ? -quot_q : quot_q);
  assign valid_o  = (state_q == DIV_DONE);
  assign ready_o  = (state_q == DIV_IDLE) ? !valid_i : ((state_q == DIV_DONE) && ready_i);

  a_div_release: assert property (@(posedge clk) disable iff (!rst_n)
    valid_o && ready_i |=> !valid_o);

  a_div_bound: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(state_q == DIV_CALC) |-> ##[1:DIV_MAX_CYCLES] (state_q != DIV_CALC));

endmodule

`default_nettype wire

// ==== src/ex_stage.sv ====
// Execute stage top level
//   ALU, multiplier and divider instances
//   Kill/halt gating, write-back select, forwarding and branch outputs
//   Stage ready/valid and the EX/WB pipeline register

`timescale 1ns/1ps
`default_nettype none

module ex_stage import ex_pkg::*; (
  input  logic        clk,
  input  logic        rst_n,
  input  id_ex_pipe_t id_ex_pipe_i,
  input  ctrl_fsm_t   ctrl_fsm_i,
  output ex_wb_pipe_t ex_wb_pipe_o,
  // Forwarding to decode
  output logic        rf_we_o,
  output rf_addr_t    rf_waddr_o,
  output logic [31:0] rf_wdata_o,
  // Branch resolution to fetch
  output logic        branch_decision_o,
  output logic [31:0] branch_target_o,
  output logic        ex_ready_o,
  output logic        ex_valid_o,
  input  logic        wb_ready_i
);

  logic        live;
  logic [31:0] alu_result;
  logic        alu_cmp_result;
  logic [31:0] mul_result;
  logic        mul_ready;
  logic        mul_valid;
  logic [31:0] div_result;
  logic        div_ready;
  logic        div_valid;
  logic        div_clz_en;
  logic [31:0] div_clz_data;
  logic [5:0]  div_clz_result;
  logic        div_shift_en;
  logic [5:0]  div_shift_amt;
  logic [31:0] div_op_b_shifted;

  // Kill and halt both suppress the instruction
  assign live = id_ex_pipe_i.instr_valid && !ctrl_fsm_i.kill_ex && !ctrl_fsm_i.halt_ex;

  assign rf_we_o    = id_ex_pipe_i.rf_we && live;
  assign rf_waddr_o = id_ex_pipe_i.rf_waddr;

  // Write-back select, ALU by default
  always_comb begin
    if (id_ex_pipe_i.mul_en) rf_wdata_o = mul_result;
    else if (id_ex_pipe_i.div_en) rf_wdata_o = div_result;
    else rf_wdata_o = alu_result;
  end

  // Fetch qualifies the decision with ex_valid_o
  assign branch_decision_o = alu_cmp_result;
  assign branch_target_o   = id_ex_pipe_i.operand_c;

  ////////////////////////////////////////////////////////////////////////////
  // Execution units
  ////////////////////////////////////////////////////////////////////////////

  ex_alu i_ex_alu (
    .operator_i         (id_ex_pipe_i.alu_operator),
    .operand_a_i        (id_ex_pipe_i.operand_a),
    .operand_b_i        (id_ex_pipe_i.operand_b),
    .div_clz_en_i       (div_clz_en),
    .div_clz_data_i     (div_clz_data),
    .div_clz_result_o   (div_clz_result),
    .div_shift_en_i     (div_shift_en),
    .div_shift_amt_i    (div_shift_amt),
    .div_op_b_shifted_o (div_op_b_shifted),
    .result_o           (alu_result),
    .cmp_result_o       (alu_cmp_result)
  );

  ex_mult i_ex_mult (
    .clk        (clk),
    .rst_n      (rst_n),
    .operator_i (id_ex_pipe_i.mul_operator),
    .op_a_i     (id_ex_pipe_i.operand_a),
    .op_b_i     (id_ex_pipe_i.operand_b),
    .result_o   (mul_result),
    .valid_i    (id_ex_pipe_i.mul_en && live),
    .ready_o    (mul_ready),
    .valid_o    (mul_valid),
    .ready_i    (wb_ready_i)
  );

  ex_div i_ex_div (
    .clk                (clk),
    .rst_n              (rst_n),
    .operator_i         (id_ex_pipe_i.div_operator),
    .op_a_i             (id_ex_pipe_i.operand_a),
    .op_b_i             (id_ex_pipe_i.operand_b),
    .alu_clz_result_i   (div_clz_result),
    .alu_clz_en_o       (div_clz_en),
    .alu_clz_data_o     (div_clz_data),
    .alu_op_b_shifted_i (div_op_b_shifted),
    .alu_shift_en_o     (div_shift_en),
    .alu_shift_amt_o    (div_shift_amt),
    .result_o           (div_result),
    .valid_i            (id_ex_pipe_i.div_en && live),
    .ready_o            (div_ready),
    .valid_o            (div_valid),
    .ready_i            (wb_ready_i)
  );

  // Kill frees the stage at once, otherwise units and write-back must agree
  assign ex_ready_o = ctrl_fsm_i.kill_ex ||
                      (wb_ready_i && mul_ready && div_ready && !ctrl_fsm_i.halt_ex);

  // ALU results are valid in the cycle they are presented
  assign ex_valid_o = live &&
    ((id_ex_pipe_i.alu_en && !id_ex_pipe_i.mul_en && !id_ex_pipe_i.div_en) ||
     (id_ex_pipe_i.mul_en && mul_valid) ||
     (id_ex_pipe_i.div_en && div_valid));

  ////////////////////////////////////////////////////////////////////////////
  // EX/WB pipeline register
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ex_wb_pipe_o <= '0;
    end else if (ex_valid_o && wb_ready_i) begin
      ex_wb_pipe_o.instr_valid <= 1'b1;
      ex_wb_pipe_o.rf_we       <= id_ex_pipe_i.rf_we;
      ex_wb_pipe_o.rf_waddr    <= id_ex_pipe_i.rf_waddr;
      ex_wb_pipe_o.rf_wdata    <= rf_wdata_o;
      ex_wb_pipe_o.pc          <= id_ex_pipe_i.pc;
    end else if (wb_ready_i) begin
      // Nothing to hand over, insert a bubble
      ex_wb_pipe_o.instr_valid <= 1'b0;
      ex_wb_pipe_o.rf_we       <= 1'b0;
    end
  end

  a_one_long_unit: assert property (@(posedge clk) disable iff (!rst_n)
    id_ex_pipe_i.instr_valid |-> !(id_ex_pipe_i.mul_en && id_ex_pipe_i.div_en));

  // The divider never borrows the shifter from a live ALU shift
  a_shifter_free: assert property (@(posedge clk) disable iff (!rst_n)
    live && id_ex_pipe_i.alu_en && (id_ex_pipe_i.alu_operator inside {SLL, SRL, SRA})
    |-> !div_shift_en && !div_clz_en);

endmodule

`default_nettype wire

// ==== verification/tb_ex_checks.sv ====
// Concurrent checks on the execute stage outputs
//   Reset values, ALU/branch results, forwarding, multiplier latency
//   Long-unit stalls, halt/kill behavior, EX/WB order and hold

`timescale 1ns/1ps
`default_nettype none

module tb_ex_checks import ex_pkg::*; (
  input  logic        clk,
  input  logic        rst_n,
  input  id_ex_pipe_t id_ex_pipe_i,
  input  ctrl_fsm_t   ctrl_fsm_i,
  input  logic        wb_ready_i,
  input  ex_wb_pipe_t ex_wb_pipe_i,
  input  logic        rf_we_i,
  input  rf_addr_t    rf_waddr_i,
  input  logic [31:0] rf_wdata_i,
  input  logic        branch_decision_i,
  input  logic [31:0] branch_target_i,
  input  logic        ex_ready_i,
  input  logic        ex_valid_i,
  // Reference model values for the presented instruction
  input  logic        fresh_i,
  input  logic [31:0] exp_wdata_i,
  input  logic        exp_cmp_i,
  // Oldest entry still expected in EX/WB
  input  ex_wb_pipe_t exp_head_i,
  input  int          exp_count_i,
  output logic        error_o
);

  logic live;
  logic alu_only;
  logic long_op;

  assign live     = id_ex_pipe_i.instr_valid && !ctrl_fsm_i.kill_ex && !ctrl_fsm_i.halt_ex;
  assign alu_only = id_ex_pipe_i.alu_en && !id_ex_pipe_i.mul_en && !id_ex_pipe_i.div_en;
  assign long_op  = id_ex_pipe_i.mul_en || id_ex_pipe_i.div_en;

  initial error_o = 1'b0;

  task automatic flag_error(input string msg);
    $display("error %0t: %s", $time, msg);
    error_o = 1'b1;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Reset and result values
  ////////////////////////////////////////////////////////////////////////////

  // During reset and on the first edge after it
  a_reset: assert property (@(posedge clk) (!rst_n || $rose(rst_n)) |->
    !ex_wb_pipe_i.instr_valid && !ex_wb_pipe_i.rf_we && !ex_valid_i)
    else flag_error("EX/WB or ex_valid_o not cleared by reset");

  a_alu_valid: assert property (@(posedge clk) disable iff (!rst_n)
    live && alu_only |-> ex_valid_i)
    else flag_error("ALU instruction not valid in its first cycle");

  // Any result the stage declares valid must match the model
  a_wdata: assert property (@(posedge clk) disable iff (!rst_n)
    live && ex_valid_i |-> rf_wdata_i == exp_wdata_i)
    else flag_error("rf_wdata_o differs from model");

  // Forwarding follows the presented instruction while it is live
  a_fwd_live: assert property (@(posedge clk) disable iff (!rst_n)
    live |-> rf_we_i == id_ex_pipe_i.rf_we && rf_waddr_i == id_ex_pipe_i.rf_waddr)
    else flag_error("forwarding write enable or address differs from instruction");

  // Bubbles, killed and halted instructions never forward
  a_fwd_dead: assert property (@(posedge clk) disable iff (!rst_n)
    !live |-> !rf_we_i)
    else flag_error("rf_we_o high without a live instruction");

  a_branch: assert property (@(posedge clk) disable iff (!rst_n)
    live && alu_only |->
    branch_decision_i == exp_cmp_i && branch_target_i == id_ex_pipe_i.operand_c)
    else flag_error("branch decision or target differs from model");

  ////////////////////////////////////////////////////////////////////////////
  // Timing and control
  ////////////////////////////////////////////////////////////////////////////

  // Multiply result one cycle after presentation unless halted or killed
  a_mul_latency: assert property (@(posedge clk) disable iff (!rst_n)
    fresh_i && live && id_ex_pipe_i.mul_en |-> !ex_valid_i ##1 (!live || ex_valid_i))
    else flag_error("multiply valid not exactly one cycle after issue");

  a_long_stall: assert property (@(posedge clk) disable iff (!rst_n)
    live && long_op && !ex_valid_i |-> !ex_ready_i)
    else flag_error("ex_ready_o high before long unit result");

  a_halt: assert property (@(posedge clk) disable iff (!rst_n)
    ctrl_fsm_i.halt_ex && !ctrl_fsm_i.kill_ex |-> !ex_valid_i && !ex_ready_i)
    else flag_error("halt did not stall the stage");

  a_kill: assert property (@(posedge clk) disable iff (!rst_n)
    ctrl_fsm_i.kill_ex |-> ex_ready_i && !ex_valid_i)
    else flag_error("kill did not free the stage");

  a_wb_hold: assert property (@(posedge clk) disable iff (!rst_n)
    !wb_ready_i |=> $stable(ex_wb_pipe_i))
    else flag_error("EX/WB changed under back-pressure");

  // Retired entries appear once each in issue order and never when killed
  a_wb_order: assert property (@(posedge clk) disable iff (!rst_n)
    ex_wb_pipe_i.instr_valid |-> exp_count_i != 0 && ex_wb_pipe_i == exp_head_i)
    else flag_error("EX/WB entry differs from expected order or content");

endmodule

`default_nettype wire

// ==== verification/tb_ex_stage.sv ====
// Testbench top for the execute stage
//   Clock, reset and watchdog
//   Random instruction driver acting as decode and write-back
//   Reference model and expected EX/WB queue

`timescale 1ns/1ps
`default_nettype none

module tb_ex_stage import ex_pkg::*; ();

  localparam int  NUM_INSTR   = 400;
  localparam real WATCHDOG_NS = (NUM_INSTR * DIV_MAX_CYCLES + 20) * 40.0;

  logic        clk = 1'b0;
  logic        rst_n;
  id_ex_pipe_t id_ex_pipe;
  ctrl_fsm_t   ctrl_fsm;
  logic        wb_ready;
  ex_wb_pipe_t ex_wb_pipe;
  logic        rf_we;
  rf_addr_t    rf_waddr;
  logic [31:0] rf_wdata;
  logic        branch_decision;
  logic [31:0] branch_target;
  logic        ex_ready;
  logic        ex_valid;
  integer      seed;
  int          issued;
  logic [31:0] pc_next;
  logic        handed = 1'b0;
  logic        fresh;
  logic [31:0] exp_wdata;
  logic        exp_cmp;
  ex_wb_pipe_t exp_q[$];
  ex_wb_pipe_t exp_head = '0;
  int          exp_count = 0;
  logic        check_error;

  always #20 clk = ~clk;

  ex_stage i_ex_stage (
    .clk               (clk),
    .rst_n             (rst_n),
    .id_ex_pipe_i      (id_ex_pipe),
    .ctrl_fsm_i        (ctrl_fsm),
    .ex_wb_pipe_o      (ex_wb_pipe),
    .rf_we_o           (rf_we),
    .rf_waddr_o        (rf_waddr),
    .rf_wdata_o        (rf_wdata),
    .branch_decision_o (branch_decision),
    .branch_target_o   (branch_target),
    .ex_ready_o        (ex_ready),
    .ex_valid_o        (ex_valid),
    .wb_ready_i        (wb_ready)
  );

  tb_ex_checks i_checks (
    .clk (clk), .rst_n (rst_n), .id_ex_pipe_i (id_ex_pipe), .ctrl_fsm_i (ctrl_fsm),
    .wb_ready_i (wb_ready), .ex_wb_pipe_i (ex_wb_pipe), .rf_we_i (rf_we),
    .rf_waddr_i (rf_waddr), .rf_wdata_i (rf_wdata),
    .branch_decision_i (branch_decision), .branch_target_i (branch_target),
    .ex_ready_i (ex_ready), .ex_valid_i (ex_valid), .fresh_i (fresh),
    .exp_wdata_i (exp_wdata), .exp_cmp_i (exp_cmp), .exp_head_i (exp_head),
    .exp_count_i (exp_count), .error_o (check_error)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Reference model following the RISC-V RV32IM rules
  ////////////////////////////////////////////////////////////////////////////

  function automatic logic cmp_model(input alu_op_e op, input logic [31:0] a, b);
    case (op)
      EQ:        return a == b;
      NE:        return a != b;
      LT, SLT:   return $signed(a) < $signed(b);
      GE:        return $signed(a) >= $signed(b);
      LTU, SLTU: return a < b;
      GEU:       return a >= b;
      default:   return 1'b0;
    endcase
  endfunction

  function automatic logic [31:0] alu_model(input alu_op_e op, input logic [31:0] a, b);
    case (op)
      ADD:     return a + b;
      SUB:     return a - b;
      XOR:     return a ^ b;
      OR:      return a | b;
      AND:     return a & b;
      SLL:     return a << b[4:0];
      SRL:     return a >> b[4:0];
      SRA:     return $signed(a) >>> b[4:0];
      default: return {31'd0, cmp_model(op, a, b)};
    endcase
  endfunction

  function automatic logic [31:0] mul_model(input mul_op_e op, input logic [31:0] a, b);
    logic [63:0] p;
    case (op)
      MUL:     p = {32'd0, a} * {32'd0, b};
      MULH:    p = $signed({{32{a[31]}}, a}) * $signed({{32{b[31]}}, b});
      MULHSU:  p = $signed({{32{a[31]}}, a}) * $signed({32'd0, b});
      default: p = {32'd0, a} * {32'd0, b};
    endcase
    return (op == MUL) ? p[31:0] : p[63:32];
  endfunction

  function automatic logic [31:0] div_model(input div_op_e op, input logic [31:0] a, b);
    logic signed [31:0] sa;
    logic signed [31:0] sb;
    logic               ovf;
    sa  = a;
    sb  = b;
    ovf = (a == 32'h8000_0000) && (b == 32'hffff_ffff);
    // Zero divisor gives an all-ones quotient and the dividend as remainder
    if (b == 32'd0) return (op == DIV || op == DIVU) ? 32'hffff_ffff : a;
    case (op)
      DIV: begin
        if (ovf) return a;
        return sa / sb;
      end
      DIVU:    return a / b;
      REM: begin
        if (ovf) return 32'd0;
        return sa % sb;
      end
      default: return a % b;
    endcase
  endfunction

  function automatic logic [31:0] rnd();
    rnd = $random(seed);
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////////////////////

  // Present a new instruction or an occasional bubble and compute its model results
  task automatic next_instr();
    logic [31:0] r;
    r = rnd();
    id_ex_pipe = '0;
    if (r[3:0] == 4'd0) return;
    id_ex_pipe.instr_valid  = 1'b1;
    id_ex_pipe.pc           = pc_next;
    id_ex_pipe.alu_operator = alu_op_e'(r[7:4]);
    id_ex_pipe.mul_operator = mul_op_e'(r[9:8]);
    id_ex_pipe.div_operator = div_op_e'(r[11:10]);
    id_ex_pipe.mul_en       = (r[14:12] < 3'd2);
    id_ex_pipe.div_en       = (r[14:12] == 3'd2) || (r[14:12] == 3'd3);
    id_ex_pipe.alu_en       = !id_ex_pipe.mul_en && !id_ex_pipe.div_en;
    id_ex_pipe.operand_a    = rnd();
    // Smaller divisors give longer divides
    id_ex_pipe.operand_b    = rnd() >> r[20:16];
    id_ex_pipe.operand_c    = rnd();
    id_ex_pipe.rf_we        = r[21];
    id_ex_pipe.rf_waddr     = r[26:22];
    if (id_ex_pipe.div_en && r[29:27] == 3'd0) id_ex_pipe.operand_b = 32'd0;
    if (id_ex_pipe.div_en && r[29:27] == 3'd1) begin
      id_ex_pipe.operand_a = 32'h8000_0000;
      id_ex_pipe.operand_b = 32'hffff_ffff;
    end
    pc_next = pc_next + 32'd4;
    issued++;
    exp_cmp = cmp_model(id_ex_pipe.alu_operator, id_ex_pipe.operand_a, id_ex_pipe.operand_b);
    if (id_ex_pipe.mul_en)
      exp_wdata = mul_model(id_ex_pipe.mul_operator, id_ex_pipe.operand_a, id_ex_pipe.operand_b);
    else if (id_ex_pipe.div_en)
      exp_wdata = div_model(id_ex_pipe.div_operator, id_ex_pipe.operand_a, id_ex_pipe.operand_b);
    else
      exp_wdata = alu_model(id_ex_pipe.alu_operator, id_ex_pipe.operand_a, id_ex_pipe.operand_b);
  endtask

  task automatic fail_run();
    $display("** FAIL **");
    $fatal(1, "Simulation stopped on failure");
  endtask

  // Decode handshake and the expected EX/WB queue
  always @(posedge clk) begin
    ex_wb_pipe_t entry;
    handed <= ex_ready;
    if (rst_n) begin
      if (ex_wb_pipe.instr_valid && wb_ready && exp_q.size() > 0) void'(exp_q.pop_front());
      if (ex_ready && id_ex_pipe.instr_valid && !ctrl_fsm.kill_ex) begin
        entry = '0;
        entry.instr_valid = 1'b1;
        entry.rf_we       = id_ex_pipe.rf_we;
        entry.rf_waddr    = id_ex_pipe.rf_waddr;
        entry.rf_wdata    = exp_wdata;
        entry.pc          = id_ex_pipe.pc;
        exp_q.push_back(entry);
      end
      exp_head  = (exp_q.size() > 0) ? exp_q[0] : '0;
      exp_count = exp_q.size();
    end
  end

  always @(posedge check_error) fail_run();

  initial begin
    #(WATCHDOG_NS);
    $display("Watchdog expired, the stage stopped making progress");
    fail_run();
  end

  initial begin
    seed       = 32'h1553b2c2;
    rst_n      = 1'b1;
    id_ex_pipe = '0;
    ctrl_fsm   = '0;
    wb_ready   = 1'b0;
    fresh      = 1'b0;
    exp_wdata  = '0;
    exp_cmp    = 1'b0;
    pc_next    = 32'h0000_1000;
    issued     = 0;
    #1 rst_n = 1'b0;
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    while (issued < NUM_INSTR) begin
      fresh = handed || !id_ex_pipe.instr_valid;
      if (fresh) next_instr();
      fresh = fresh && id_ex_pipe.instr_valid;
      wb_ready         = (rnd() & 32'd15) < 32'd13;
      ctrl_fsm.kill_ex = (rnd() & 32'd31) == 32'd0;
      ctrl_fsm.halt_ex = (rnd() & 32'd31) == 32'd0;
      @(negedge clk);
    end
    // Let the last instruction retire, then drain with bubbles
    fresh    = 1'b0;
    ctrl_fsm = '0;
    wb_ready = 1'b1;
    while (!handed) @(negedge clk);
    id_ex_pipe = '0;
    repeat (4) @(negedge clk);
    if (exp_q.size() != 0) begin
      $display("error %0t: %0d instructions never reached EX/WB", $time, exp_q.size());
      fail_run();
    end else begin
      $display("** PASS **");
      $finish;
    end
  end

endmodule

`default_nettype wire

// ==== all.f ====
src/ex_pkg.sv
src/ex_alu.sv
src/ex_mult.sv
src/ex_div.sv
src/ex_stage.sv
verification/tb_ex_checks.sv
verification/tb_ex_stage.sv

// ==== Bender.yml ====
package:
  name: ex_stage

sources:
  - files:
      - src/ex_pkg.sv
      - src/ex_alu.sv
      - src/ex_mult.sv
      - src/ex_div.sv
      - src/ex_stage.sv
  - target: test
    files:
      - verification/tb_ex_checks.sv
      - verification/tb_ex_stage.sv
